// File: Makefile
sim:
	rm -f sim.log
	verilator --binary --timing --assert -f tsc_pipe.f \
		--top-module tb_tsc_pipe --Mdir build -o tb_tsc_pipe
	./build/tb_tsc_pipe > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf build sim.log

// File: common/isa_pkg.sv
`default_nettype none
`include "tsc_params.svh"

package isa_pkg;

	typedef logic [`TSC_WORD_SIZE-1:0] word_t;
	typedef logic [$clog2(`TSC_NUM_REGS)-1:0] reg_addr_t;

	typedef enum logic [3:0] {
		op_bne = 4'd0,
		op_beq = 4'd1,
		op_adi = 4'd4,
		op_ori = 4'd5,
		op_lhi = 4'd6,
		op_lwd = 4'd7,
		op_swd = 4'd8,
		op_jmp = 4'd9,
		op_rtype = 4'd15 // register-register, func selects the operation
	} opcode_t;

	typedef enum logic [5:0] {
		fn_add = 6'd0,
		fn_sub = 6'd1,
		fn_and = 6'd2,
		fn_orr = 6'd3,
		fn_wwd = 6'd28,
		fn_hlt = 6'd29
	} func_t;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_lhi,
		alu_pass_b
	} alu_op_t;

	// instruction field positions
	localparam int opcode_hi = 15;
	localparam int opcode_lo = 12;
	localparam int rs_hi = 11;
	localparam int rs_lo = 10;
	localparam int rt_hi = 9;
	localparam int rt_lo = 8;
	localparam int rd_hi = 7;
	localparam int rd_lo = 6;
	localparam int func_hi = 5;
	localparam int func_lo = 0;
	localparam int imm_hi = 7;
	localparam int imm_lo = 0;
	localparam int target_hi = 11;
	localparam int target_lo = 0;

endpackage

`default_nettype wire

// File: common/pipe_pkg.sv
`default_nettype none

package pipe_pkg;
	import isa_pkg::*;

	typedef struct packed {
		alu_op_t alu_op;
		logic alu_src_imm; // b operand from ext_imm instead of rt
		logic is_branch_eq;
		logic is_branch_ne;
		logic is_jump;
		logic mem_read;
		logic mem_write;
		logic reg_write;
		logic is_wwd;
		logic is_hlt;
	} ctrl_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t rs_val;
		word_t rt_val;
		word_t ext_imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result; // also the data address for LWD/SWD
		word_t rs_val;
		word_t rt_val; // store data
		reg_addr_t dest;
		word_t target;
		logic taken;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t ctrl;
		word_t alu_result;
		word_t load_data;
		word_t rs_val; // WWD value
		reg_addr_t dest;
	} mem_wb_t;

	// operand source in execute
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

`default_nettype wire

// File: common/tsc_params.svh
`ifndef TSC_PARAMS_SVH
`define TSC_PARAMS_SVH

// data and address width
`define TSC_WORD_SIZE 16

// architectural registers
`define TSC_NUM_REGS 4

// first fetch address after reset
`define TSC_RESET_PC 0

`endif

// File: decode/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_params.svh"

module inst_decoder
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input word_t inst,
	input word_t pc,
	output ctrl_t ctrl,
	output reg_addr_t rs,
	output reg_addr_t rt,
	output reg_addr_t dest,
	output logic uses_rt,
	output word_t ext_imm
);

	opcode_t opcode;
	func_t func;
	logic [imm_hi-imm_lo:0] imm;
	logic [target_hi-target_lo:0] target;

	assign opcode = opcode_t'(inst[opcode_hi:opcode_lo]);
	assign func = func_t'(inst[func_hi:func_lo]);
	assign rs = inst[rs_hi:rs_lo];
	assign rt = inst[rt_hi:rt_lo];
	assign imm = inst[imm_hi:imm_lo];
	assign target = inst[target_hi:target_lo];

	// immediates and loads write rt, register ops write rd
	assign dest = (opcode == op_rtype) ? inst[rd_hi:rd_lo] : rt;

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = alu_pass_b;
		uses_rt = 1'b0;
		ext_imm = word_t'($signed(imm));
		case (opcode)
			op_rtype: begin
				case (func)
					fn_add: ctrl.alu_op = alu_add;
					fn_sub: ctrl.alu_op = alu_sub;
					fn_and: ctrl.alu_op = alu_and;
					fn_orr: ctrl.alu_op = alu_or;
					fn_wwd: ctrl.is_wwd = 1'b1;
					fn_hlt: ctrl.is_hlt = 1'b1;
					default: ;
				endcase
				ctrl.reg_write = func inside {fn_add, fn_sub, fn_and, fn_orr};
				uses_rt = ctrl.reg_write; // WWD reads rs only
			end
			op_adi: begin
				ctrl.alu_op = alu_add;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_ori: begin
				ctrl.alu_op = alu_or;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ext_imm = word_t'(imm);
			end
			op_lhi: begin
				ctrl.alu_op = alu_lhi;
				ctrl.alu_src_imm = 1'b1;
				ctrl.reg_write = 1'b1;
				ext_imm = word_t'(imm) << 8;
			end
			op_lwd: begin
				ctrl.alu_op = alu_add; // rs + offset
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			op_swd: begin
				ctrl.alu_op = alu_add;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write = 1'b1;
				uses_rt = 1'b1; // store data
			end
			op_beq: begin
				ctrl.is_branch_eq = 1'b1;
				uses_rt = 1'b1;
			end
			op_bne: begin
				ctrl.is_branch_ne = 1'b1;
				uses_rt = 1'b1;
			end
			op_jmp: begin
				ctrl.is_jump = 1'b1;
				ext_imm = {pc[`TSC_WORD_SIZE-1:target_hi+1], target};
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// File: decode/register_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_params.svh"

module register_file
	import isa_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_addr_t rs_addr,
	input reg_addr_t rt_addr,
	input reg_addr_t wr_addr,
	input logic wr_en,
	input word_t wr_data,
	output word_t rs_data,
	output word_t rt_data
);

	word_t regs [`TSC_NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `TSC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wr_addr] <= wr_data;
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rs_data = (wr_en && wr_addr == rs_addr) ? wr_data : regs[rs_addr];
	assign rt_data = (wr_en && wr_addr == rt_addr) ? wr_data : regs[rt_addr];

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_params.svh"

module alu
	import isa_pkg::*;
(
	input word_t a,
	input word_t b,
	input alu_op_t op,
	output word_t result,
	output logic equal
);

	always_comb begin
		case (op)
			alu_add: begin
				result = a + b; // wraps at 16 bits
			end
			alu_sub: begin
				result = a - b;
			end
			alu_and: begin
				result = a & b;
			end
			alu_or: begin
				result = a | b;
			end
			alu_lhi: begin
				// imm arrives already in the high byte
				result = {b[`TSC_WORD_SIZE-1:8], 8'h00};
			end
			default: begin
				result = b;
			end
		endcase
	end

	// branch compare of rs and rt
	assign equal = (a == b);

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_unit
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input reg_addr_t id_rs,
	input reg_addr_t id_rt,
	input logic id_uses_rt,
	input reg_addr_t ex_dest,
	input logic ex_mem_read,
	input logic ex_valid,
	input reg_addr_t ex_rs,
	input reg_addr_t ex_rt,
	input reg_addr_t mem_dest,
	input logic mem_reg_write,
	input logic mem_valid,
	input reg_addr_t wb_dest,
	input logic wb_reg_write,
	input logic wb_valid,
	output logic stall,
	output fwd_sel_t fwd_a,
	output fwd_sel_t fwd_b
);

	logic mem_fwd_ok;
	logic wb_fwd_ok;

	// rs is treated as a source for every instruction
	assign stall = ex_valid && ex_mem_read &&
		(ex_dest == id_rs || (id_uses_rt && ex_dest == id_rt));

	// a load never sits in memory with its user in execute, the stall prevents it
	assign mem_fwd_ok = mem_valid && mem_reg_write;
	assign wb_fwd_ok = wb_valid && wb_reg_write;

	always_comb begin
		fwd_a = fwd_reg;
		if (mem_fwd_ok && mem_dest == ex_rs) fwd_a = fwd_mem;
		else if (wb_fwd_ok && wb_dest == ex_rs) fwd_a = fwd_wb;
		fwd_b = fwd_reg;
		if (mem_fwd_ok && mem_dest == ex_rt) fwd_b = fwd_mem;
		else if (wb_fwd_ok && wb_dest == ex_rt) fwd_b = fwd_wb;
	end

endmodule

`default_nettype wire

// File: logic/stage_reg.sv
`timescale 1ns/1ps
`default_nettype none

module stage_reg #(
	parameter type payload_t = logic
) (
	input logic clk,
	input logic reset,
	input logic stall,
	input logic flush,
	input logic bubble,
	input logic in_valid,
	input payload_t in_data,
	output logic out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (reset) begin
			out_valid <= 1'b0;
		end else if (flush) begin
			out_valid <= 1'b0; // squashed by a redirect
		end else if (!stall) begin
			out_valid <= in_valid & ~bubble;
		end
	end

	// payload only matters while out_valid is set
	always_ff @(posedge clk) begin
		if (!stall) begin
			out_data <= in_data;
		end
	end

endmodule

`default_nettype wire

// File: logic/tsc_pipe.sv
`timescale 1ns/1ps
`default_nettype none
`include "tsc_params.svh"

module tsc_pipe
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input logic clk,
	input logic reset,
	output logic inst_read,
	output word_t inst_addr,
	input word_t inst_data,
	output logic data_read,
	output logic data_write,
	output word_t data_addr,
	output word_t data_wdata,
	input word_t data_rdata,
	output word_t num_inst,
	output word_t output_port,
	output logic is_halted
);

	typedef logic [2*`TSC_WORD_SIZE-1:0] if_id_t; // {pc, inst}

	word_t pc;
	logic halt_r;
	logic hazard_stall;
	logic redirect;

	logic if_id_valid;
	if_id_t if_id_q;
	word_t id_pc;
	word_t id_inst;
	ctrl_t id_ctrl;
	reg_addr_t id_rs;
	reg_addr_t id_rt;
	reg_addr_t id_dest;
	logic id_uses_rt;
	word_t id_ext_imm;
	word_t id_rs_val;
	word_t id_rt_val;
	id_ex_t id_ex_d;

	logic ex_valid;
	id_ex_t id_ex_q;
	fwd_sel_t fwd_a;
	fwd_sel_t fwd_b;
	word_t ex_a;
	word_t ex_rt_val;
	word_t ex_b;
	word_t ex_result;
	logic ex_equal;
	logic ex_taken;
	word_t ex_target;
	ex_mem_t ex_mem_d;

	logic mem_valid;
	ex_mem_t ex_mem_q;
	mem_wb_t mem_wb_d;

	logic wb_valid;
	mem_wb_t mem_wb_q;
	word_t wb_result;

	function automatic word_t fwd_pick(fwd_sel_t sel, word_t reg_val, word_t mem_val,
			word_t wb_val);
		case (sel)
			fwd_mem: return mem_val;
			fwd_wb: return wb_val;
			default: return reg_val;
		endcase
	endfunction

	// halt takes effect while HLT is still in writeback so nothing younger retires
	assign is_halted = halt_r | (wb_valid & mem_wb_q.ctrl.is_hlt);
	assign inst_read = ~reset & ~is_halted;
	assign inst_addr = pc;
	assign redirect = mem_valid & ex_mem_q.taken & ~is_halted;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= word_t'(`TSC_RESET_PC);
		end else if (redirect) begin
			pc <= ex_mem_q.target;
		end else if (inst_read && !hazard_stall) begin
			pc <= pc + 1'b1;
		end
	end

	stage_reg #(.payload_t(if_id_t)) u_if_id (
		.clk(clk),
		.reset(reset),
		.stall(hazard_stall | is_halted),
		.flush(redirect),
		.bubble(1'b0),
		.in_valid(inst_read),
		.in_data({pc, inst_data}),
		.out_valid(if_id_valid),
		.out_data(if_id_q)
	);

	assign {id_pc, id_inst} = if_id_q;

	inst_decoder u_decoder (
		.inst(id_inst),
		.pc(id_pc),
		.ctrl(id_ctrl),
		.rs(id_rs),
		.rt(id_rt),
		.dest(id_dest),
		.uses_rt(id_uses_rt),
		.ext_imm(id_ext_imm)
	);

	register_file u_regs (
		.clk(clk),
		.reset(reset),
		.rs_addr(id_rs),
		.rt_addr(id_rt),
		.wr_addr(mem_wb_q.dest),
		.wr_en(wb_valid & mem_wb_q.ctrl.reg_write),
		.wr_data(wb_result),
		.rs_data(id_rs_val),
		.rt_data(id_rt_val)
	);

	assign id_ex_d = '{ctrl: id_ctrl, pc: id_pc, rs: id_rs, rt: id_rt, dest: id_dest,
		rs_val: id_rs_val, rt_val: id_rt_val, ext_imm: id_ext_imm};

	stage_reg #(.payload_t(id_ex_t)) u_id_ex (
		.clk(clk),
		.reset(reset),
		.stall(is_halted),
		.flush(redirect),
		.bubble(hazard_stall), // load-use bubble
		.in_valid(if_id_valid),
		.in_data(id_ex_d),
		.out_valid(ex_valid),
		.out_data(id_ex_q)
	);

	hazard_unit u_hazard (
		.id_rs(id_rs),
		.id_rt(id_rt),
		.id_uses_rt(id_uses_rt),
		.ex_dest(id_ex_q.dest),
		.ex_mem_read(id_ex_q.ctrl.mem_read),
		.ex_valid(ex_valid),
		.ex_rs(id_ex_q.rs),
		.ex_rt(id_ex_q.rt),
		.mem_dest(ex_mem_q.dest),
		.mem_reg_write(ex_mem_q.ctrl.reg_write),
		.mem_valid(mem_valid),
		.wb_dest(mem_wb_q.dest),
		.wb_reg_write(mem_wb_q.ctrl.reg_write),
		.wb_valid(wb_valid),
		.stall(hazard_stall),
		.fwd_a(fwd_a),
		.fwd_b(fwd_b)
	);

	assign ex_a = fwd_pick(fwd_a, id_ex_q.rs_val, ex_mem_q.alu_result, wb_result);
	assign ex_rt_val = fwd_pick(fwd_b, id_ex_q.rt_val, ex_mem_q.alu_result, wb_result);
	assign ex_b = id_ex_q.ctrl.alu_src_imm ? id_ex_q.ext_imm : ex_rt_val;

	alu u_alu (
		.a(ex_a),
		.b(ex_b),
		.op(id_ex_q.ctrl.alu_op),
		.result(ex_result),
		.equal(ex_equal)
	);

	assign ex_taken = (id_ex_q.ctrl.is_branch_eq & ex_equal) |
		(id_ex_q.ctrl.is_branch_ne & ~ex_equal) | id_ex_q.ctrl.is_jump;
	// decoder already formed the full jump address
	assign ex_target = id_ex_q.ctrl.is_jump ? id_ex_q.ext_imm
		: id_ex_q.pc + 1'b1 + id_ex_q.ext_imm;

	assign ex_mem_d = '{ctrl: id_ex_q.ctrl, alu_result: ex_result, rs_val: ex_a,
		rt_val: ex_rt_val, dest: id_ex_q.dest, target: ex_target, taken: ex_taken};

	stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
		.clk(clk),
		.reset(reset),
		.stall(is_halted),
		.flush(redirect),
		.bubble(1'b0),
		.in_valid(ex_valid),
		.in_data(ex_mem_d),
		.out_valid(mem_valid),
		.out_data(ex_mem_q)
	);

	assign data_read = mem_valid & ex_mem_q.ctrl.mem_read & ~is_halted;
	assign data_write = mem_valid & ex_mem_q.ctrl.mem_write & ~is_halted;
	assign data_addr = ex_mem_q.alu_result;
	assign data_wdata = ex_mem_q.rt_val;

	assign mem_wb_d = '{ctrl: ex_mem_q.ctrl, alu_result: ex_mem_q.alu_result,
		load_data: data_rdata, rs_val: ex_mem_q.rs_val, dest: ex_mem_q.dest};

	stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(clk),
		.reset(reset),
		.stall(is_halted),
		.flush(1'b0),
		.bubble(1'b0),
		.in_valid(mem_valid),
		.in_data(mem_wb_d),
		.out_valid(wb_valid),
		.out_data(mem_wb_q)
	);

	assign wb_result = mem_wb_q.ctrl.mem_read ? mem_wb_q.load_data : mem_wb_q.alu_result;

	always_ff @(posedge clk) begin
		if (reset) begin
			halt_r <= 1'b0;
			num_inst <= '0;
			output_port <= '0;
		end else if (wb_valid && !halt_r) begin
			num_inst <= num_inst + 1'b1; // HLT itself counts
			if (mem_wb_q.ctrl.is_wwd) output_port <= mem_wb_q.rs_val;
			if (mem_wb_q.ctrl.is_hlt) halt_r <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_tsc_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tsc_pipe;

	localparam int num_rows = 5;

	logic clk;
	logic reset;
	logic inst_read;
	logic [15:0] inst_addr;
	logic [15:0] inst_data;
	logic data_read;
	logic data_write;
	logic [15:0] data_addr;
	logic [15:0] data_wdata;
	logic [15:0] data_rdata;
	logic [15:0] num_inst;
	logic [15:0] output_port;
	logic is_halted;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [15:0] dmem_ref [256]; // expected contents that reset copies into dmem

	string row_name [num_rows];
	logic [15:0] prog [num_rows][12];
	logic [15:0] exp_out [num_rows][4];
	int exp_n [num_rows];
	int exp_count [num_rows];
	int mem_pos [num_rows]; // output slot taken from dmem_ref or -1
	int mem_addr [num_rows];

	logic [15:0] seen [$];
	logic [15:0] last_out;
	int errors;

	tsc_pipe dut0 (
		.clk(clk),
		.reset(reset),
		.inst_read(inst_read),
		.inst_addr(inst_addr),
		.inst_data(inst_data),
		.data_read(data_read),
		.data_write(data_write),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.num_inst(num_inst),
		.output_port(output_port),
		.is_halted(is_halted)
	);

	bind tsc_pipe tsc_pipe_checker u_checker (
		.clk(clk),
		.reset(reset),
		.inst_read(inst_read),
		.data_read(data_read),
		.data_write(data_write),
		.is_halted(is_halted)
	);

	// memories answer only to their read strobes
	assign inst_data = inst_read ? imem[inst_addr[7:0]] : 16'h0000;
	assign data_rdata = data_read ? dmem[data_addr[7:0]] : 16'h0000;

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++) dmem[i] <= dmem_ref[i];
		end else if (data_write) begin
			dmem[data_addr[7:0]] <= data_wdata;
		end
	end

	// log every new value on the output port
	always @(posedge clk) begin
		if (reset) begin
			last_out = 16'h0000;
		end else if (output_port !== last_out) begin
			seen.push_back(output_port);
			last_out = output_port;
		end
	end

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [15:0] enc_r(int fn, int rs, int rt, int rd);
		return {4'hf, 2'(rs), 2'(rt), 2'(rd), 6'(fn)};
	endfunction

	function automatic logic [15:0] enc_i(int op, int rs, int rt, int imm);
		return {4'(op), 2'(rs), 2'(rt), 8'(imm)};
	endfunction

	task automatic compare(input string name, input logic [15:0] expected,
			input logic [15:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic build_table();
		for (int r = 0; r < num_rows; r++) begin
			for (int i = 0; i < 12; i++) prog[r][i] = enc_r(29, 0, 0, 0);
			mem_pos[r] = -1;
			mem_addr[r] = 0;
		end
		row_name[0] = "arith";
		prog[0] = '{enc_i(6, 0, 1, 8'h12), enc_i(5, 1, 1, 8'h34), enc_i(4, 1, 2, 8'hfe),
			enc_r(0, 1, 2, 3), enc_r(28, 3, 0, 0), enc_r(1, 2, 3, 0), enc_r(2, 0, 3, 1),
			enc_r(3, 1, 2, 2), enc_r(28, 2, 0, 0), enc_r(0, 0, 0, 3), enc_r(28, 3, 0, 0),
			enc_r(29, 0, 0, 0)};
		exp_out[0] = '{16'h2466, 16'h3676, 16'hdb98, 16'h0000};
		exp_n[0] = 3;
		exp_count[0] = 12;
		row_name[1] = "load_use";
		prog[1][0:8] = '{enc_i(6, 0, 1, 8'hab), enc_i(5, 1, 1, 8'hcd), enc_i(5, 0, 2, 8'h10),
			enc_i(8, 2, 1, 0), enc_i(7, 2, 3, 0), enc_r(28, 3, 0, 0), enc_i(7, 2, 0, 8'h20),
			enc_r(28, 0, 0, 0), enc_r(29, 0, 0, 0)};
		exp_out[1] = '{16'habcd, 16'h0000, 16'h0000, 16'h0000};
		exp_n[1] = 2;
		exp_count[1] = 9;
		mem_pos[1] = 1;
		mem_addr[1] = 8'h30;
		row_name[2] = "branch";
		prog[2] = '{enc_i(5, 0, 1, 5), enc_i(5, 0, 2, 8'h7e), enc_i(1, 1, 0, 1),
			enc_r(28, 1, 0, 0), enc_i(0, 1, 0, 1), enc_r(28, 2, 0, 0), enc_i(1, 1, 1, 1),
			enc_r(28, 2, 0, 0), enc_i(0, 2, 2, 1), enc_i(4, 1, 1, 1), enc_r(28, 1, 0, 0),
			enc_r(29, 0, 0, 0)};
		exp_out[2] = '{16'h0005, 16'h0006, 16'h0000, 16'h0000};
		exp_n[2] = 2;
		exp_count[2] = 10; // the two marker WWDs are squashed
		row_name[3] = "jump";
		prog[3][0:6] = '{enc_i(5, 0, 1, 8'h21), 16'h9004, enc_r(28, 1, 0, 0),
			enc_i(5, 0, 1, 8'h55), enc_i(4, 1, 1, 1), enc_r(28, 1, 0, 0), enc_r(29, 0, 0, 0)};
		exp_out[3] = '{16'h0022, 16'h0000, 16'h0000, 16'h0000};
		exp_n[3] = 1;
		exp_count[3] = 5;
		row_name[4] = "halt";
		prog[4][0:4] = '{enc_i(5, 0, 3, 8'h3c), enc_i(5, 0, 2, 8'h99), enc_r(28, 3, 0, 0),
			enc_r(29, 0, 0, 0), enc_r(28, 2, 0, 0)};
		exp_out[4] = '{16'h003c, 16'h0000, 16'h0000, 16'h0000};
		exp_n[4] = 1;
		exp_count[4] = 4;
	endtask

	initial begin
		repeat (num_rows * 200) @(posedge clk);
		$display("timeout: a program never halted within %0d cycles", num_rows * 200);
		$display("Test failures found");
		$finish;
	end

	initial begin
		int unsigned v;
		logic [15:0] expected;
		reset = 1'b1;
		errors = 0;
		last_out = 16'h0000;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 16'h0000;
			dmem_ref[i] = 16'h0000;
		end
		v = $urandom(61);
		build_table();
		for (int r = 0; r < num_rows; r++) begin
			@(posedge clk);
			reset <= 1'b1;
			for (int i = 0; i < 256; i++) begin
				v = $urandom;
				dmem_ref[i] = v[15:0];
				imem[i] = (i < 12) ? prog[r][i] : 16'h0000;
			end
			repeat (16) @(posedge clk);
			seen.delete();
			reset <= 1'b0;
			while (is_halted !== 1'b1) @(posedge clk);
			repeat (10) @(posedge clk); // frozen pipeline must stay quiet
			compare({row_name[r], " is_halted"}, 16'h0001, {15'h0000, is_halted});
			compare({row_name[r], " inst_read"}, 16'h0000, {15'h0000, inst_read});
			compare({row_name[r], " num_inst"}, 16'(exp_count[r]), num_inst);
			compare({row_name[r], " output count"}, 16'(exp_n[r]), 16'(seen.size()));
			for (int k = 0; k < exp_n[r] && k < seen.size(); k++) begin
				expected = (k == mem_pos[r]) ? dmem_ref[mem_addr[r]] : exp_out[r][k];
				compare($sformatf("%s output %0d", row_name[r], k), expected, seen[k]);
			end
		end
		$display("closing: %0d error(s) in %0d programs", errors, num_rows);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb/tsc_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tsc_pipe_checker (
	input logic clk,
	input logic reset,
	input logic inst_read,
	input logic data_read,
	input logic data_write,
	input logic is_halted
);

	// one memory strobe per cycle
	assert property (@(posedge clk) disable iff (reset) !(data_read && data_write))
		else $error("data_read and data_write are high together");

	// halt is sticky until the next reset
	assert property (@(posedge clk) disable iff (reset) is_halted |=> is_halted)
		else $error("is_halted dropped without a reset");

	// no fetch while reset is held
	assert property (@(posedge clk) reset |-> !inst_read)
		else $error("inst_read is high during reset");

endmodule

`default_nettype wire

// File: tsc_pipe.f
+incdir+common
common/isa_pkg.sv
common/pipe_pkg.sv
logic/stage_reg.sv
decode/inst_decoder.sv
decode/register_file.sv
logic/alu.sv
logic/hazard_unit.sv
logic/tsc_pipe.sv
tb/tsc_pipe_checker.sv
tb/tb_tsc_pipe.sv
